// File: hw/dcache_cfg.svh
// No size may be zero and DC_SETS and DC_REPLAY_ELS must be powers of two of at least 2
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Number of peer cache ports sharing the memory bus
`define DC_NUM_PORTS 2

// Word address width
`define DC_ADDR_WIDTH 12

// Data word width
`define DC_DATA_WIDTH 32

// Lines per cache, one word each
`define DC_SETS 16

// Replay FIFO depth per port
`define DC_REPLAY_ELS 8

`endif

// File: hw/dcache_pkg.sv
// Word accesses only and addresses count words not bytes
`include "dcache_cfg.svh"

package dcache_pkg;

   localparam int dc_index_width_lp = $clog2(`DC_SETS);

   typedef logic [`DC_ADDR_WIDTH-1:0] dc_addr_t;
   typedef logic [`DC_DATA_WIDTH-1:0] dc_data_t;

   typedef enum logic
   {
      e_op_load  = 1'b0,
      e_op_store = 1'b1
   } dc_op_e;

   typedef struct packed
   {
      dc_op_e   op;
      dc_addr_t addr;
      dc_data_t data;
   } dc_req_t;

   typedef logic [dc_index_width_lp-1:0] dc_index_t;
   typedef logic [`DC_ADDR_WIDTH-dc_index_width_lp-1:0] dc_tag_t;

   // Miss machine
   typedef enum logic [1:0]
   {
      e_ready,
      e_send,
      e_wait
   } dc_state_e;

endpackage

// File: hw/mem_bus_pkg.sv
// Every command gets exactly one response and writes answer with any data
`include "dcache_cfg.svh"

package mem_bus_pkg;

   localparam int mem_port_id_width_lp = (`DC_NUM_PORTS > 1) ? $clog2(`DC_NUM_PORTS) : 1;

   typedef struct packed
   {
      logic                 write;
      dcache_pkg::dc_addr_t addr;
      dcache_pkg::dc_data_t data;
   } mem_cmd_t;

   typedef logic [mem_port_id_width_lp-1:0] mem_port_id_t;

   typedef enum logic
   {
      e_idle,
      e_busy
   } arb_state_e;

endpackage

// File: hw/mem_bus_if.sv
// One command in flight per client and the client holds cmd_v and cmd until cmd_ready
interface mem_bus_if;

   import dcache_pkg::*;
   import mem_bus_pkg::*;

   logic     cmd_v;
   mem_cmd_t cmd;
   logic     cmd_ready;

   // Response has no back-pressure
   logic     resp_v;
   dc_data_t resp_data;

   modport client (output cmd_v, cmd, input cmd_ready, resp_v, resp_data);

   modport arbiter (input cmd_v, cmd, output cmd_ready, resp_v, resp_data);

endinterface

// File: hw/replay_fifo.sv
// Entries leave only on retire_i and roll_i rewinds reads to the oldest unretired entry
`include "dcache_cfg.svh"

module replay_fifo
   (input                        clk_i
   ,input                        reset_i

   ,input                        v_i
   ,input  dcache_pkg::dc_req_t  req_i
   ,output logic                 ready_o

   ,output logic                 v_o
   ,output dcache_pkg::dc_req_t  req_o
   ,input                        yumi_i

   ,input                        roll_i
   ,input                        retire_i
   );

   import dcache_pkg::*;

   // One extra bit tells full from empty
   localparam int ptr_width_lp = $clog2(`DC_REPLAY_ELS) + 1;

   dc_req_t                 mem_r [`DC_REPLAY_ELS];
   logic [ptr_width_lp-1:0] wptr_r;
   logic [ptr_width_lp-1:0] rptr_r;
   logic [ptr_width_lp-1:0] cptr_r;
   logic                    enq;

   assign enq     = v_i && ready_o;
   assign ready_o = (wptr_r - cptr_r) != ptr_width_lp'(`DC_REPLAY_ELS);
   assign v_o     = (rptr_r != wptr_r);
   assign req_o   = mem_r[rptr_r[ptr_width_lp-2:0]];

   always_ff @(posedge clk_i)
   begin
      if (enq)
         mem_r[wptr_r[ptr_width_lp-2:0]] <= req_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wptr_r <= '0;
         rptr_r <= '0;
         cptr_r <= '0;
      end
      else
      begin
         if (enq)
            wptr_r <= wptr_r + 1'b1;

         // Rollback beats a read in the same cycle
         if (roll_i)
            rptr_r <= cptr_r + ptr_width_lp'(retire_i);
         else if (yumi_i)
            rptr_r <= rptr_r + 1'b1;

         if (retire_i)
            cptr_r <= cptr_r + 1'b1;
      end
   end

   // Only entries already handed to the cache can retire
   a_retire_read: assert property (@(posedge clk_i) disable iff (reset_i)
      retire_i |-> (cptr_r != rptr_r));

endmodule

// File: hw/dcache_slice.sv
// Write-through with no allocate on a store miss and v_i means the request is already taken
`include "dcache_cfg.svh"

module dcache_slice
   (input                         clk_i
   ,input                         reset_i

   ,input                         v_i
   ,input  dcache_pkg::dc_req_t   req_i
   ,output logic                  ready_o

   ,output logic                  v_o
   ,output dcache_pkg::dc_data_t  data_o
   ,output logic                  poison_o

   ,mem_bus_if.client             mem
   );

   import dcache_pkg::*;

   localparam int index_width_lp = $bits(dc_index_t);

   dc_tag_t             tag_mem_r  [`DC_SETS];
   dc_data_t            data_mem_r [`DC_SETS];
   logic [`DC_SETS-1:0] valid_r;

   logic      s1_v_r;
   dc_req_t   s1_req_r;
   dc_index_t s1_index;

   logic      s2_v_r;
   dc_req_t   s2_req_r;
   dc_tag_t   s2_tag_r;
   dc_data_t  s2_data_r;
   logic      s2_valid_r;
   dc_index_t s2_index;
   logic      s2_store;
   logic      s2_hit;
   logic      s2_ok;
   logic      st_commit;

   logic      wbuf_v_r;
   dc_addr_t  wbuf_addr_r;
   dc_data_t  wbuf_data_r;
   logic      fill_pend_r;
   dc_addr_t  fill_addr_r;
   dc_index_t fill_index;
   logic      fill_done;
   dc_state_e state_r;
   dc_state_e state_n;

   assign s1_index   = s1_req_r.addr[index_width_lp-1:0];
   assign s2_index   = s2_req_r.addr[index_width_lp-1:0];
   assign fill_index = fill_addr_r[index_width_lp-1:0];

   // Stage 2 hit check
   assign s2_store  = (s2_req_r.op == e_op_store);
   assign s2_hit    = s2_valid_r
                      && (s2_tag_r == s2_req_r.addr[`DC_ADDR_WIDTH-1:index_width_lp]);
   assign s2_ok     = s2_store ? !wbuf_v_r : s2_hit;
   assign st_commit = s2_v_r && s2_store && s2_ok;

   assign v_o      = s2_v_r && s2_ok;
   assign poison_o = s2_v_r && !s2_ok;
   assign data_o   = s2_store ? '0 : s2_data_r;
   assign ready_o  = !fill_pend_r && !poison_o;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         s1_v_r <= 1'b0;
         s2_v_r <= 1'b0;
      end
      else
      begin
         // Poison also flushes stage 1
         s1_v_r <= v_i && !poison_o;
         s2_v_r <= s1_v_r && !poison_o;
      end
   end

   // Stage 1 array read
   always_ff @(posedge clk_i)
   begin
      s1_req_r   <= req_i;
      s2_req_r   <= s1_req_r;
      s2_tag_r   <= tag_mem_r[s1_index];
      s2_valid_r <= valid_r[s1_index];
      // Store hit landing on the line being read
      if (st_commit && s2_hit && (s2_index == s1_index))
         s2_data_r <= s2_req_r.data;
      else
         s2_data_r <= data_mem_r[s1_index];
   end

   always_ff @(posedge clk_i)
   begin
      if (fill_done)
      begin
         data_mem_r[fill_index] <= mem.resp_data;
         tag_mem_r[fill_index]  <= fill_addr_r[`DC_ADDR_WIDTH-1:index_width_lp];
      end
      else if (st_commit && s2_hit)
         data_mem_r[s2_index] <= s2_req_r.data;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         valid_r <= '0;
      else if (fill_done)
         valid_r[fill_index] <= 1'b1;
   end

   // Write buffer and pending miss payloads
   always_ff @(posedge clk_i)
   begin
      if (st_commit)
      begin
         wbuf_addr_r <= s2_req_r.addr;
         wbuf_data_r <= s2_req_r.data;
      end
      if (poison_o && !s2_store)
         fill_addr_r <= s2_req_r.addr;
   end

   // A response with the buffer full answers the write
   assign fill_done = (state_r == e_wait) && mem.resp_v && !wbuf_v_r;

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         e_ready: if (wbuf_v_r || fill_pend_r) state_n = e_send;
         e_send:  if (mem.cmd_ready) state_n = e_wait;
         e_wait:  if (mem.resp_v) state_n = e_ready;
         default: state_n = e_ready;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r     <= e_ready;
         wbuf_v_r    <= 1'b0;
         fill_pend_r <= 1'b0;
      end
      else
      begin
         state_r <= state_n;
         if (st_commit)
            wbuf_v_r <= 1'b1;
         else if ((state_r == e_wait) && mem.resp_v)
            wbuf_v_r <= 1'b0;
         if (poison_o && !s2_store)
            fill_pend_r <= 1'b1;
         else if (fill_done)
            fill_pend_r <= 1'b0;
      end
   end

   // Pending write goes out ahead of the fill
   assign mem.cmd_v = (state_r == e_send);
   assign mem.cmd   = '{write: wbuf_v_r
                       ,addr : wbuf_v_r ? wbuf_addr_r : fill_addr_r
                       ,data : wbuf_data_r};

   a_result_or_poison: assert property (@(posedge clk_i) disable iff (reset_i)
      !(v_o && poison_o));

   // Command held until the arbiter takes it
   a_cmd_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      mem.cmd_v && !mem.cmd_ready |=> mem.cmd_v && $stable(mem.cmd));

endmodule

// File: hw/mem_arbiter.sv
// Holds one grant from command to response and expects no response without a command
`include "dcache_cfg.svh"

module mem_arbiter
   (input                          clk_i
   ,input                          reset_i

   ,mem_bus_if.arbiter             clients [`DC_NUM_PORTS]

   ,output logic                   mem_cmd_v_o
   ,output mem_bus_pkg::mem_cmd_t  mem_cmd_o
   ,input                          mem_cmd_ready_i

   ,input                          mem_resp_v_i
   ,input  dcache_pkg::dc_data_t   mem_resp_data_i
   ,output logic                   mem_resp_yumi_o
   );

   import mem_bus_pkg::*;

   logic [`DC_NUM_PORTS-1:0] req_v;
   logic [`DC_NUM_PORTS-1:0] sel;
   mem_cmd_t                 req_cmd [`DC_NUM_PORTS];
   arb_state_e               state_r;
   mem_port_id_t             grant_r;
   mem_port_id_t             grant_n;
   logic                     found;

   for (genvar i = 0; i < `DC_NUM_PORTS; i++)
   begin : g_client
      assign req_v[i]   = clients[i].cmd_v;
      assign req_cmd[i] = clients[i].cmd;
      assign sel[i]     = (state_r == e_busy) && (grant_r == mem_port_id_t'(i));

      assign clients[i].cmd_ready = sel[i] && mem_cmd_ready_i;
      assign clients[i].resp_v    = sel[i] && mem_resp_v_i;
      assign clients[i].resp_data = mem_resp_data_i;
   end

   // Search starts just after the last grant
   always_comb
   begin
      mem_port_id_t cand;
      grant_n = grant_r;
      found   = 1'b0;
      for (int k = 1; k <= `DC_NUM_PORTS; k++)
      begin
         cand = mem_port_id_t'((int'(grant_r) + k) % `DC_NUM_PORTS);
         if (!found && req_v[cand])
         begin
            grant_n = cand;
            found   = 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r <= e_idle;
         grant_r <= '0;
      end
      else
      begin
         case (state_r)
            e_idle:
            begin
               if (found)
               begin
                  state_r <= e_busy;
                  grant_r <= grant_n;
               end
            end
            e_busy: if (mem_resp_v_i) state_r <= e_idle;
            default: state_r <= e_idle;
         endcase
      end
   end

   assign mem_cmd_v_o     = (state_r == e_busy) && req_v[grant_r];
   assign mem_cmd_o       = req_cmd[grant_r];
   assign mem_resp_yumi_o = mem_resp_v_i;

   a_resp_in_busy: assert property (@(posedge clk_i) disable iff (reset_i)
      mem_resp_v_i |-> (state_r == e_busy));

endmodule

// File: hw/dcache_harness.sv
// Ports need disjoint address ranges because the caches are not coherent with each other
`include "dcache_cfg.svh"

module dcache_harness
   (input                                               clk_i
   ,input                                               reset_i

   ,input        [`DC_NUM_PORTS-1:0]                    v_i
   ,input  dcache_pkg::dc_req_t [`DC_NUM_PORTS-1:0]     req_i
   ,output logic [`DC_NUM_PORTS-1:0]                    ready_o

   ,output logic [`DC_NUM_PORTS-1:0]                    v_o
   ,output dcache_pkg::dc_data_t [`DC_NUM_PORTS-1:0]    data_o

   ,output logic                                        mem_cmd_v_o
   ,output mem_bus_pkg::mem_cmd_t                       mem_cmd_o
   ,input                                               mem_cmd_ready_i

   ,input                                               mem_resp_v_i
   ,input  dcache_pkg::dc_data_t                        mem_resp_data_i
   ,output logic                                        mem_resp_yumi_o
   );

   import dcache_pkg::*;

   logic    [`DC_NUM_PORTS-1:0] fifo_v;
   logic    [`DC_NUM_PORTS-1:0] fifo_yumi;
   logic    [`DC_NUM_PORTS-1:0] cache_ready;
   logic    [`DC_NUM_PORTS-1:0] poison;
   dc_req_t [`DC_NUM_PORTS-1:0] fifo_req;

   mem_bus_if bus [`DC_NUM_PORTS] ();

   for (genvar i = 0; i < `DC_NUM_PORTS; i++)
   begin : g_port
      replay_fifo fifo
         (.clk_i(clk_i)
         ,.reset_i(reset_i)
         ,.v_i(v_i[i])
         ,.req_i(req_i[i])
         ,.ready_o(ready_o[i])
         ,.v_o(fifo_v[i])
         ,.req_o(fifo_req[i])
         ,.yumi_i(fifo_yumi[i])
         ,.roll_i(poison[i])
         ,.retire_i(v_o[i])
         );

      assign fifo_yumi[i] = fifo_v[i] && cache_ready[i];

      dcache_slice slice
         (.clk_i(clk_i)
         ,.reset_i(reset_i)
         ,.v_i(fifo_yumi[i])
         ,.req_i(fifo_req[i])
         ,.ready_o(cache_ready[i])
         ,.v_o(v_o[i])
         ,.data_o(data_o[i])
         ,.poison_o(poison[i])
         ,.mem(bus[i])
         );
   end

   mem_arbiter arb
      (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.clients(bus)
      ,.mem_cmd_v_o(mem_cmd_v_o)
      ,.mem_cmd_o(mem_cmd_o)
      ,.mem_cmd_ready_i(mem_cmd_ready_i)
      ,.mem_resp_v_i(mem_resp_v_i)
      ,.mem_resp_data_i(mem_resp_data_i)
      ,.mem_resp_yumi_o(mem_resp_yumi_o)
      );

endmodule

// File: tb/tb_mem_model.sv
// Accepts one command at a time and answers it after a random delay of zero to four cycles
`include "dcache_cfg.svh"

module tb_mem_model
   (input                          clk_i
   ,input                          reset_i

   ,input                          cmd_v_i
   ,input  mem_bus_pkg::mem_cmd_t  cmd_i
   ,output logic                   cmd_ready_o

   ,output logic                   resp_v_o
   ,output dcache_pkg::dc_data_t   resp_data_o
   );

   import dcache_pkg::*;

   dc_data_t mem_r [2**`DC_ADDR_WIDTH];
   logic     busy_r;
   int       delay_r;

   initial
   begin
      for (int a = 0; a < 2**`DC_ADDR_WIDTH; a++)
         mem_r[a] = dc_data_t'(a) ^ 32'h5a5a5a5a;
      cmd_ready_o = 1'b0;
      resp_v_o    = 1'b0;
      resp_data_o = '0;
      busy_r      = 1'b0;
      delay_r     = 0;
   end

   // Command seen here is the one the next rising edge samples
   always @(negedge clk_i)
   begin
      cmd_ready_o = 1'b0;
      resp_v_o    = 1'b0;
      if (reset_i)
         busy_r = 1'b0;
      else if (busy_r)
      begin
         if (delay_r == 0)
         begin
            resp_v_o = 1'b1;
            busy_r   = 1'b0;
         end
         else
            delay_r = delay_r - 1;
      end
      else if (cmd_v_i && ($urandom_range(3) != 0))
      begin
         cmd_ready_o = 1'b1;
         busy_r      = 1'b1;
         delay_r     = $urandom_range(4);
         if (cmd_i.write)
         begin
            mem_r[cmd_i.addr] = cmd_i.data;
            // Write answers carry junk
            resp_data_o       = $urandom;
         end
         else
            resp_data_o = mem_r[cmd_i.addr];
      end
   end

endmodule

// File: tb/tb_dcache_harness.sv
// At most four ports fit because each 64-word port range starts on a 1024-word boundary
`include "dcache_cfg.svh"

module tb_dcache_harness;

   import dcache_pkg::*;
   import mem_bus_pkg::*;

   localparam int num_reqs_lp    = 300;
   localparam int range_words_lp = 64;
   localparam int stride_lp      = 1024;
   // Roughly twice the worst bus cost per request on the shared bus
   localparam int timeout_lp     = num_reqs_lp * `DC_NUM_PORTS * 16;

   typedef struct packed
   {
      logic     store;
      dc_data_t data;
   } exp_t;

   logic                          clk;
   logic                          reset;
   logic     [`DC_NUM_PORTS-1:0]  v;
   dc_req_t  [`DC_NUM_PORTS-1:0]  req;
   logic     [`DC_NUM_PORTS-1:0]  ready;
   logic     [`DC_NUM_PORTS-1:0]  res_v;
   dc_data_t [`DC_NUM_PORTS-1:0]  res_data;
   logic                          mem_cmd_v;
   mem_cmd_t                      mem_cmd;
   logic                          mem_cmd_ready;
   logic                          mem_resp_v;
   dc_data_t                      mem_resp_data;
   logic                          mem_resp_yumi;

   dc_data_t shadow [2**`DC_ADDR_WIDTH];
   exp_t     res_q  [`DC_NUM_PORTS][$];
   dc_req_t  wr_q   [`DC_NUM_PORTS][$];
   int       issued [`DC_NUM_PORTS];

   // Expectations for the coming rising edge
   logic     [`DC_NUM_PORTS-1:0]  exp_v;
   exp_t     [`DC_NUM_PORTS-1:0]  exp_res;
   logic     [`DC_NUM_PORTS-1:0]  exp_ready;
   logic     [`DC_NUM_PORTS-1:0]  wr_exp_v;
   dc_req_t  [`DC_NUM_PORTS-1:0]  wr_exp;
   logic     [`DC_NUM_PORTS-1:0]  wr_fire;
   logic                          outstanding;
   int                            cycles;
   int                            errors;
   int                            results;

   dcache_harness dut_i
      (.clk_i(clk)
      ,.reset_i(reset)
      ,.v_i(v)
      ,.req_i(req)
      ,.ready_o(ready)
      ,.v_o(res_v)
      ,.data_o(res_data)
      ,.mem_cmd_v_o(mem_cmd_v)
      ,.mem_cmd_o(mem_cmd)
      ,.mem_cmd_ready_i(mem_cmd_ready)
      ,.mem_resp_v_i(mem_resp_v)
      ,.mem_resp_data_i(mem_resp_data)
      ,.mem_resp_yumi_o(mem_resp_yumi)
      );

   tb_mem_model mem_i
      (.clk_i(clk)
      ,.reset_i(reset)
      ,.cmd_v_i(mem_cmd_v)
      ,.cmd_i(mem_cmd)
      ,.cmd_ready_o(mem_cmd_ready)
      ,.resp_v_o(mem_resp_v)
      ,.resp_data_o(mem_resp_data)
      );

   initial
      clk = 1'b0;

   always #5 clk = ~clk;

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (reset)
      begin
         cycles      <= 0;
         outstanding <= 1'b0;
         wr_fire     <= '0;
      end
      else
      begin
         if (mem_cmd_v && mem_cmd_ready)
            outstanding <= 1'b1;
         else if (mem_resp_v)
            outstanding <= 1'b0;
         for (int p = 0; p < `DC_NUM_PORTS; p++)
            wr_fire[p] <= mem_cmd_v && mem_cmd_ready && mem_cmd.write
                          && ((int'(mem_cmd.addr) / stride_lp) == p);
      end
   end

   function automatic logic all_done();
      logic d;
      d = 1'b1;
      for (int p = 0; p < `DC_NUM_PORTS; p++)
         if ((issued[p] < num_reqs_lp) || (res_q[p].size() != 0) || (wr_q[p].size() != 0))
            d = 1'b0;
      return d;
   endfunction

   // Called on the falling edge, where all DUT outputs are settled
   task automatic drive_and_track();
      dc_req_t r;
      for (int p = 0; p < `DC_NUM_PORTS; p++)
      begin
         // Requests without a result still sit in the replay FIFO
         exp_ready[p] = (res_q[p].size() < `DC_REPLAY_ELS);

         exp_v[p] = 1'b0;
         if (res_v[p] && (res_q[p].size() != 0))
         begin
            exp_v[p]   = 1'b1;
            exp_res[p] = res_q[p].pop_front();
            results++;
         end
         if (wr_fire[p] && (wr_q[p].size() != 0))
            void'(wr_q[p].pop_front());

         v[p] = 1'b0;
         if ((issued[p] < num_reqs_lp) && ready[p] && ($urandom_range(3) != 0))
         begin
            r.op   = ($urandom_range(1) != 0) ? e_op_store : e_op_load;
            r.addr = dc_addr_t'(p * stride_lp + $urandom_range(range_words_lp - 1));
            r.data = $urandom;
            v[p]   = 1'b1;
            req[p] = r;
            issued[p]++;
            if (r.op == e_op_store)
            begin
               shadow[r.addr] = r.data;
               res_q[p].push_back(exp_t'{store: 1'b1, data: '0});
               wr_q[p].push_back(r);
            end
            else
               res_q[p].push_back(exp_t'{store: 1'b0, data: shadow[r.addr]});
         end

         wr_exp_v[p] = (wr_q[p].size() != 0);
         if (wr_exp_v[p])
            wr_exp[p] = wr_q[p][0];
      end
   endtask

   for (genvar p = 0; p < `DC_NUM_PORTS; p++)
   begin : g_port_check
      a_order: assert property (@(posedge clk) disable iff (reset)
         res_v[p] |-> exp_v[p])
      else
      begin
         errors++;
         $display("Port %0d returned a result with no request outstanding", p);
      end

      a_load_data: assert property (@(posedge clk) disable iff (reset)
         res_v[p] && exp_v[p] && !exp_res[p].store |-> (res_data[p] == exp_res[p].data))
      else
      begin
         errors++;
         $display("[ERROR] load_data port %0d: expected %h, actual %h",
                  p, exp_res[p].data, $sampled(res_data[p]));
      end

      a_store_result: assert property (@(posedge clk) disable iff (reset)
         res_v[p] && exp_v[p] && exp_res[p].store |-> (res_data[p] == '0))
      else
      begin
         errors++;
         $display("[ERROR] store_result port %0d: expected %h, actual %h",
                  p, dc_data_t'(0), $sampled(res_data[p]));
      end

      a_ready: assert property (@(posedge clk) disable iff (reset)
         ready[p] == exp_ready[p])
      else
      begin
         errors++;
         $display("[ERROR] ready port %0d: expected %b, actual %b",
                  p, exp_ready[p], $sampled(ready[p]));
      end

      a_write_through: assert property (@(posedge clk) disable iff (reset)
         mem_cmd_v && mem_cmd_ready && mem_cmd.write && ((int'(mem_cmd.addr) / stride_lp) == p)
         |-> wr_exp_v[p] && (mem_cmd.addr == wr_exp[p].addr) && (mem_cmd.data == wr_exp[p].data))
      else
      begin
         errors++;
         $display("[ERROR] write_through port %0d: expected %h:%h, actual %h:%h",
                  p, wr_exp[p].addr, wr_exp[p].data,
                  $sampled(mem_cmd.addr), $sampled(mem_cmd.data));
      end
   end

   a_cmd_stable: assert property (@(posedge clk) disable iff (reset)
      mem_cmd_v && !mem_cmd_ready |=> mem_cmd_v && $stable(mem_cmd))
   else
   begin
      errors++;
      $display("Memory command changed or dropped before it was accepted");
   end

   a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
      outstanding |-> !mem_cmd_v)
   else
   begin
      errors++;
      $display("A memory command was issued before the previous response arrived");
   end

   a_resp_yumi: assert property (@(posedge clk) disable iff (reset)
      mem_resp_v |-> mem_resp_yumi)
   else
   begin
      errors++;
      $display("Memory response was not taken in the cycle it arrived");
   end

   a_reset_quiet: assert property (@(posedge clk)
      $past(reset) |-> (res_v == '0) && !mem_cmd_v)
   else
   begin
      errors++;
      $display("[ERROR] reset: expected v_o %h and mem_cmd_v_o 0, actual %h and %b",
               {`DC_NUM_PORTS{1'b0}}, $sampled(res_v), $sampled(mem_cmd_v));
   end

   initial
   begin
      void'($urandom(32'hf108));
      reset     = 1'b1;
      v         = '0;
      req       = '0;
      exp_v     = '0;
      exp_res   = '0;
      exp_ready = '1;
      wr_exp_v  = '0;
      wr_exp    = '0;
      errors    = 0;
      results   = 0;
      for (int a = 0; a < 2**`DC_ADDR_WIDTH; a++)
         shadow[a] = dc_data_t'(a) ^ 32'h5a5a5a5a;
      for (int p = 0; p < `DC_NUM_PORTS; p++)
         issued[p] = 0;

      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      while (!all_done() && (cycles < timeout_lp))
      begin
         @(negedge clk);
         drive_and_track();
      end
      repeat (2) @(posedge clk);

      if (!all_done())
      begin
         errors++;
         $display("Timeout after %0d cycles with requests still in flight", cycles);
      end
      $display("Run finished: %0d errors, %0d results, %0d cycles", errors, results, cycles);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// File: sim.f
+incdir+hw
hw/dcache_pkg.sv
hw/mem_bus_pkg.sv
hw/mem_bus_if.sv
hw/replay_fifo.sv
hw/dcache_slice.sv
hw/mem_arbiter.sv
hw/dcache_harness.sv
tb/tb_mem_model.sv
tb/tb_dcache_harness.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_dcache_harness -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_dcache_harness > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
   exit 1
fi
exit 0
